// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_readout_gate
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== blink_divider.sv ====
// slow and fast square blink levels for the status leds
// each level is low for DIV/2 cycles then high for DIV/2, from reset release
`timescale 1ns/1ps
`default_nettype none

module blink_divider #(
    parameter int SLOW_DIV = readout_pkg::SLOW_DIV_DEFAULT,
    parameter int FAST_DIV = readout_pkg::FAST_DIV_DEFAULT
) (
    input  wire  CLK40,
    input  wire  i_arst_n,
    output logic o_blink_slow,
    output logic o_blink_fast
);

    // index 0 slow, index 1 fast
    logic [1:0] blink;

    for (genvar g = 0; g < 2; g++)
    begin : g_div
        localparam int HALF = ((g == 0) ? SLOW_DIV : FAST_DIV) / 2;
        localparam int CW = $clog2(2 * HALF);

        logic [CW-1:0] cnt;

        // wraps after one full period of 2*HALF cycles
        always_ff @(posedge CLK40 or negedge i_arst_n)
        begin
            if (!i_arst_n)
                cnt <= '0;
            else if (cnt == CW'(2 * HALF - 1))
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end

        // second half of the period is the on phase
        assign blink[g] = (cnt >= CW'(HALF));
    end

    assign o_blink_slow = blink[0];
    assign o_blink_fast = blink[1];

endmodule

`default_nettype wire

// ==== drain_timer.sv ====
// counts consecutive cycles with every enabled front-end fifo empty
// fifo status arrives from the receiver clock and is synchronized first
// o_drained goes high once the count reaches MAX_WAIT
`timescale 1ns/1ps
`default_nettype none

module drain_timer #(
    parameter int MAX_WAIT = readout_pkg::MAX_WAIT_DEFAULT
) (
    input  wire                          CLK40,
    input  wire                          i_arst_n,
    input  wire [readout_pkg::N_CH-1:0] i_rx_enabled,
    input  wire [readout_pkg::N_CH-1:0] i_fe_fifo_empty,
    input  wire                          i_timer_clear,
    input  wire                          i_timer_run,
    output logic                         o_drained
);

    localparam int CW = $clog2(MAX_WAIT + 1);
    localparam int LAST = readout_pkg::SYNC_STAGES - 1;

    logic [readout_pkg::N_CH-1:0] en_sync [readout_pkg::SYNC_STAGES];
    logic [readout_pkg::N_CH-1:0] empty_sync [readout_pkg::SYNC_STAGES];
    logic [CW-1:0]                empty_cnt;
    logic                         busy;

    // flop chain into CLK40, stage 0 may go metastable
    always_ff @(posedge CLK40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int s = 0; s < readout_pkg::SYNC_STAGES; s++)
            begin
                en_sync[s] <= '0;
                empty_sync[s] <= '0;
            end
        end
        else
        begin
            en_sync[0] <= i_rx_enabled;
            empty_sync[0] <= i_fe_fifo_empty;
            for (int s = 1; s < readout_pkg::SYNC_STAGES; s++)
            begin
                en_sync[s] <= en_sync[s-1];
                empty_sync[s] <= empty_sync[s-1];
            end
        end
    end

    // disabled channels never hold off the acknowledge
    assign busy = |(en_sync[LAST] & ~empty_sync[LAST]);

    // clear wins over counting, any pending data restarts from zero
    always_ff @(posedge CLK40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
            empty_cnt <= '0;
        else if (i_timer_clear)
            empty_cnt <= '0;
        else if (i_timer_run)
        begin
            if (busy)
                empty_cnt <= '0;
            else if (empty_cnt != CW'(MAX_WAIT))
                empty_cnt <= empty_cnt + 1'b1;
        end
    end

    // saturated count means drained
    assign o_drained = (empty_cnt == CW'(MAX_WAIT));

endmodule

`default_nettype wire

// ==== drain_wait_fsm.sv ====
// trigger acknowledge gating, CLK40 domain
// a rising cmd ready starts a wait, drained ends it, ack pulses one cycle later
// both trigger enables low force the FSM back to idle
`timescale 1ns/1ps
`default_nettype none

module drain_wait_fsm (
    input  wire  CLK40,
    input  wire  i_arst_n,
    input  wire  i_cmd_ready,
    input  wire  i_ext_trigger_enable,
    input  wire  i_trigger_enabled,
    input  wire  i_drained,
    output logic o_timer_clear,
    output logic o_timer_run,
    output logic o_readout_wait,
    output logic o_trigger_ack
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic state;
    logic cmd_ready_ff;
    logic start_edge;
    logic trig_en;
    logic fifo_ready;
    logic fifo_ready_ff;

    // both enables needed, either one low aborts a wait
    assign trig_en = i_ext_trigger_enable & i_trigger_enabled;

    // command sent, seen as rising edge of the sequencer ready level
    assign start_edge = i_cmd_ready & ~cmd_ready_ff;

    // held high in reset so a high ready level gives no edge at release
    always_ff @(posedge CLK40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
            cmd_ready_ff <= 1'b1;
        else
            cmd_ready_ff <= i_cmd_ready;
    end

    // edges during a wait or while disabled fall through and are lost
    always_ff @(posedge CLK40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= ST_IDLE;
        else if (!trig_en)
            state <= ST_IDLE;
        else if (state == ST_IDLE && start_edge)
            state <= ST_WAIT;
        else if (state == ST_WAIT && i_drained)
            state <= ST_IDLE;
    end

    // restart the empty count on the same edge that enters the wait
    assign o_timer_clear = trig_en & start_edge & (state == ST_IDLE);
    assign o_timer_run = (state == ST_WAIT);
    assign o_readout_wait = (state == ST_WAIT);

    // internal command ready level, high whenever not waiting
    assign fifo_ready = (state == ST_IDLE);

    // ack is the registered rising edge of the internal ready level
    // delayed copy starts at 1, nothing fires out of reset
    always_ff @(posedge CLK40 or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            fifo_ready_ff <= 1'b1;
            o_trigger_ack <= 1'b0;
        end
        else
        begin
            fifo_ready_ff <= fifo_ready;
            o_trigger_ack <= fifo_ready & ~fifo_ready_ff;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
readout_pkg.sv
drain_wait_fsm.sv
drain_timer.sv
blink_divider.sv
rx_status_led.sv
readout_gate_top.sv
readout_gate_props.sv
tb_readout_gate.sv

// ==== readout_gate_props.sv ====
// protocol assertions on the trigger acknowledge and readout wait
// bound into every readout_gate_top instance
`timescale 1ns/1ps
`default_nettype none

module readout_gate_props (
    input wire CLK40,
    input wire i_arst_n,
    input wire i_ext_trigger_enable,
    input wire i_trigger_enabled,
    input wire o_trigger_ack,
    input wire o_readout_wait
);

    wire trig_en = i_ext_trigger_enable & i_trigger_enabled;

    // one cycle strobe
    a_ack_single : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        o_trigger_ack |=> !o_trigger_ack)
        else $error("trigger acknowledge high two cycles in a row");

    // ack closes a wait, either drained or aborted by an enable
    a_ack_cause : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        o_trigger_ack |-> ($past(o_readout_wait, 2) || !$past(trig_en, 2)))
        else $error("trigger acknowledge without a preceding wait");

    // disabled means no wait from the next cycle on
    a_wait_gated : assert property (@(posedge CLK40) disable iff (!i_arst_n)
        !trig_en |=> !o_readout_wait)
        else $error("readout wait high while a trigger enable is low");

endmodule

bind readout_gate_top readout_gate_props props_i (
    .CLK40                (CLK40),
    .i_arst_n             (i_arst_n),
    .i_ext_trigger_enable (i_ext_trigger_enable),
    .i_trigger_enabled    (i_trigger_enabled),
    .o_trigger_ack        (o_trigger_ack),
    .o_readout_wait       (o_readout_wait)
);

`default_nettype wire

// ==== readout_gate_top.sv ====
// readout gating top level in the CLK40 domain
// holds off trigger acknowledge until enabled fe fifos have drained
// and drives the receiver and system status leds
`timescale 1ns/1ps
`default_nettype none

module readout_gate_top #(
    parameter int MAX_WAIT = readout_pkg::MAX_WAIT_DEFAULT,
    parameter int SLOW_DIV = readout_pkg::SLOW_DIV_DEFAULT,
    parameter int FAST_DIV = readout_pkg::FAST_DIV_DEFAULT
) (
    input  wire                           CLK40,
    input  wire                           i_arst_n,
    // trigger control levels
    input  wire                           i_cmd_ready,
    input  wire                           i_ext_trigger_enable,
    input  wire                           i_trigger_enabled,
    // fe status, asynchronous to CLK40
    input  wire [readout_pkg::N_CH-1:0]   i_rx_enabled,
    input  wire [readout_pkg::N_CH-1:0]   i_fe_fifo_empty,
    // led status
    input  wire [readout_pkg::N_CH-1:0]   i_rx_ready,
    input  wire [readout_pkg::N_CH-1:0]   i_rx_decoder_err,
    input  wire [readout_pkg::N_CH-1:0]   i_rx_fifo_overflow,
    input  wire [readout_pkg::N_CH-1:0]   i_rx_fifo_full,
    input  wire                           i_out_fifo_full,
    input  wire                           i_clk_locked,
    output logic                          o_trigger_ack,
    output logic                          o_readout_wait,
    output logic [readout_pkg::N_LED-1:0] o_led
);

    logic timer_clear;
    logic timer_run;
    logic drained;
    logic blink_slow;
    logic blink_fast;

    // command edge to acknowledge sequencing
    drain_wait_fsm fsm_i (
        .CLK40                (CLK40),
        .i_arst_n             (i_arst_n),
        .i_cmd_ready          (i_cmd_ready),
        .i_ext_trigger_enable (i_ext_trigger_enable),
        .i_trigger_enabled    (i_trigger_enabled),
        .i_drained            (drained),
        .o_timer_clear        (timer_clear),
        .o_timer_run          (timer_run),
        .o_readout_wait       (o_readout_wait),
        .o_trigger_ack        (o_trigger_ack)
    );

    // empty-cycle counter on synchronized fifo status
    drain_timer #(
        .MAX_WAIT (MAX_WAIT)
    ) timer_i (
        .CLK40           (CLK40),
        .i_arst_n        (i_arst_n),
        .i_rx_enabled    (i_rx_enabled),
        .i_fe_fifo_empty (i_fe_fifo_empty),
        .i_timer_clear   (timer_clear),
        .i_timer_run     (timer_run),
        .o_drained       (drained)
    );

    blink_divider #(
        .SLOW_DIV (SLOW_DIV),
        .FAST_DIV (FAST_DIV)
    ) blink_i (
        .CLK40        (CLK40),
        .i_arst_n     (i_arst_n),
        .o_blink_slow (blink_slow),
        .o_blink_fast (blink_fast)
    );

    rx_status_led led_i (
        .i_rx_ready         (i_rx_ready),
        .i_rx_decoder_err   (i_rx_decoder_err),
        .i_rx_fifo_overflow (i_rx_fifo_overflow),
        .i_rx_fifo_full     (i_rx_fifo_full),
        .i_out_fifo_full    (i_out_fifo_full),
        .i_clk_locked       (i_clk_locked),
        .i_blink_slow       (blink_slow),
        .i_blink_fast       (blink_fast),
        .o_led              (o_led)
    );

endmodule

`default_nettype wire

// ==== readout_pkg.sv ====
// constants shared by the readout gating RTL and its testbench
// referenced as readout_pkg::name, the top level passes timing values down
`default_nettype none

package readout_pkg;

    // front-end receiver channels
    localparam int N_CH = 4;

    // one led per channel plus the system led on top
    localparam int N_LED = N_CH + 1;

    // consecutive all-empty cycles before the next trigger acknowledge
    localparam int MAX_WAIT_DEFAULT = 64;

    // blink periods in CLK40 cycles, 1 Hz and about 3 Hz
    localparam int SLOW_DIV_DEFAULT = 40000000;
    localparam int FAST_DIV_DEFAULT = 13333333;

    // depth of the fifo status synchronizer
    localparam int SYNC_STAGES = 3;

endpackage

`default_nettype wire

// ==== rx_status_led.sv ====
// led driver, purely combinational
// channel leds blink slow when ready, fast on decoder error, solid on fifo trouble
// top led blinks slow or stays on with the output fifo full, only while locked
`timescale 1ns/1ps
`default_nettype none

module rx_status_led (
    input  wire [readout_pkg::N_CH-1:0]  i_rx_ready,
    input  wire [readout_pkg::N_CH-1:0]  i_rx_decoder_err,
    input  wire [readout_pkg::N_CH-1:0]  i_rx_fifo_overflow,
    input  wire [readout_pkg::N_CH-1:0]  i_rx_fifo_full,
    input  wire                          i_out_fifo_full,
    input  wire                          i_clk_locked,
    input  wire                          i_blink_slow,
    input  wire                          i_blink_fast,
    output logic [readout_pkg::N_LED-1:0] o_led
);

    always_comb
    begin
        for (int k = 0; k < readout_pkg::N_CH; k++)
        begin
            // dark unless the receiver is ready
            // overflow or full overrides the blink with a solid on
            o_led[k] = i_rx_ready[k]
                     & ((i_rx_decoder_err[k] ? i_blink_fast : i_blink_slow)
                        | i_rx_fifo_overflow[k]
                        | i_rx_fifo_full[k]);
        end

        // system led above the channel leds
        o_led[readout_pkg::N_CH] = (i_blink_slow | i_out_fifo_full) & i_clk_locked;
    end

endmodule

`default_nettype wire

// ==== tb_readout_gate.sv ====
// testbench for readout_gate_top with short wait and blink periods
// a cycle model checks wait, ack and leds every cycle against xorshift stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_readout_gate;

    localparam int MAX_WAIT = 16;
    localparam int SLOW_DIV = 8;
    localparam int FAST_DIV = 4;
    localparam int NC = readout_pkg::N_CH;
    localparam int NS = readout_pkg::SYNC_STAGES;

    logic CLK40 = 1'b0;
    logic arst_n;
    logic cmd_ready;
    logic ext_trigger_enable;
    logic trigger_enabled;
    logic [NC-1:0] rx_enabled;
    logic [NC-1:0] fe_fifo_empty;
    logic [NC-1:0] rx_ready;
    logic [NC-1:0] rx_decoder_err;
    logic [NC-1:0] rx_fifo_overflow;
    logic [NC-1:0] rx_fifo_full;
    logic out_fifo_full;
    logic clk_locked;
    logic trigger_ack;
    logic readout_wait;
    logic [readout_pkg::N_LED-1:0] led;

    // cycle model state
    logic m_cmd_ff;
    logic m_wait;
    logic m_ready_ff;
    logic m_ack;
    int m_cnt;
    int m_slow_cnt;
    int m_fast_cnt;
    logic [NC-1:0] m_en_sync [NS];
    logic [NC-1:0] m_empty_sync [NS];

    logic check_on = 1'b0;
    logic [31:0] rng = 32'hdb5ce0b4;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed = 0;

    always #20 CLK40 = ~CLK40;

    readout_gate_top #(
        .MAX_WAIT (MAX_WAIT),
        .SLOW_DIV (SLOW_DIV),
        .FAST_DIV (FAST_DIV)
    ) dut_i (
        .CLK40                (CLK40),
        .i_arst_n             (arst_n),
        .i_cmd_ready          (cmd_ready),
        .i_ext_trigger_enable (ext_trigger_enable),
        .i_trigger_enabled    (trigger_enabled),
        .i_rx_enabled         (rx_enabled),
        .i_fe_fifo_empty      (fe_fifo_empty),
        .i_rx_ready           (rx_ready),
        .i_rx_decoder_err     (rx_decoder_err),
        .i_rx_fifo_overflow   (rx_fifo_overflow),
        .i_rx_fifo_full       (rx_fifo_full),
        .i_out_fifo_full      (out_fifo_full),
        .i_clk_locked         (clk_locked),
        .o_trigger_ack        (trigger_ack),
        .o_readout_wait       (readout_wait),
        .o_led                (led)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // led rules straight from the receiver status
    function automatic logic [readout_pkg::N_LED-1:0] led_expected(input logic slow,
                                                                   input logic fast);
        logic [readout_pkg::N_LED-1:0] exp;
        for (int k = 0; k < NC; k++)
        begin
            if (!rx_ready[k])
                exp[k] = 1'b0;
            else if (rx_fifo_overflow[k] || rx_fifo_full[k])
                exp[k] = 1'b1;
            else
                exp[k] = rx_decoder_err[k] ? fast : slow;
        end
        exp[NC] = clk_locked ? (out_fifo_full | slow) : 1'b0;
        return exp;
    endfunction

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_led(input logic [readout_pkg::N_LED-1:0] got,
                             input logic [readout_pkg::N_LED-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: o_led is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic wait_for_ack(input int limit, output int cycles);
        cycles = 0;
        do
        begin
            @(negedge CLK40);
            cycles++;
        end
        while (trigger_ack !== 1'b1 && cycles < limit);
        if (trigger_ack !== 1'b1)
        begin
            errors++;
            $display("timeout: no trigger acknowledge within %0d cycles", limit);
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (readout_wait && n < limit)
        begin
            @(negedge CLK40);
            n++;
        end
        if (readout_wait)
        begin
            errors++;
            $display("timeout: readout wait still open after %0d cycles", limit);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
        begin
            failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // open a wait held by a busy channel and close it by dropping one enable
    task automatic abort_by_disable(input logic drop_ext);
        int cycles;
        int stray;
        stray = 0;
        @(posedge CLK40);
        cmd_ready <= 1'b0;
        @(posedge CLK40);
        cmd_ready <= 1'b1;
        repeat (MAX_WAIT + 8) @(posedge CLK40);
        @(negedge CLK40);
        check_level(readout_wait, 1'b1, "wait held by busy channel");
        @(posedge CLK40);
        if (drop_ext)
            ext_trigger_enable <= 1'b0;
        else
            trigger_enabled <= 1'b0;
        wait_for_ack(4, cycles);
        check_level(readout_wait, 1'b0, "wait after disable");
        // edges while disabled must start nothing
        for (int i = 0; i < 12; i++)
        begin
            @(posedge CLK40);
            cmd_ready <= i[0];
            @(negedge CLK40);
            if (readout_wait || trigger_ack)
                stray++;
        end
        if (stray != 0)
        begin
            errors++;
            $display("[ERROR] %0t ns: command edge accepted while disabled", $time);
        end
        @(posedge CLK40);
        ext_trigger_enable <= 1'b1;
        trigger_enabled <= 1'b1;
    endtask

    // cycle model sampling the inputs as they were before the edge
    always @(posedge CLK40)
    begin : model
        logic en;
        logic start;
        logic busy;
        logic drained;
        en = ext_trigger_enable & trigger_enabled;
        start = cmd_ready & ~m_cmd_ff;
        busy = |(m_en_sync[NS-1] & ~m_empty_sync[NS-1]);
        drained = (m_cnt == MAX_WAIT);
        if (!arst_n)
        begin
            m_cmd_ff <= 1'b1;
            m_wait <= 1'b0;
            m_ready_ff <= 1'b1;
            m_ack <= 1'b0;
            m_cnt <= 0;
            m_slow_cnt <= 0;
            m_fast_cnt <= 0;
            for (int s = 0; s < NS; s++)
            begin
                m_en_sync[s] <= '0;
                m_empty_sync[s] <= '0;
            end
        end
        else
        begin
            m_cmd_ff <= cmd_ready;
            m_en_sync[0] <= rx_enabled;
            m_empty_sync[0] <= fe_fifo_empty;
            for (int s = 1; s < NS; s++)
            begin
                m_en_sync[s] <= m_en_sync[s-1];
                m_empty_sync[s] <= m_empty_sync[s-1];
            end
            if (!en)
                m_wait <= 1'b0;
            else if (!m_wait && start)
                m_wait <= 1'b1;
            else if (m_wait && drained)
                m_wait <= 1'b0;
            // count restarts on entry or busy and saturates at the limit
            if (en && start && !m_wait)
                m_cnt <= 0;
            else if (m_wait)
                m_cnt <= busy ? 0 : (drained ? m_cnt : m_cnt + 1);
            // ack marks the return to idle
            m_ready_ff <= !m_wait;
            m_ack <= !m_wait && !m_ready_ff;
            m_slow_cnt <= (m_slow_cnt == SLOW_DIV - 1) ? 0 : m_slow_cnt + 1;
            m_fast_cnt <= (m_fast_cnt == FAST_DIV - 1) ? 0 : m_fast_cnt + 1;
        end
    end

    // compare in the middle of the cycle when everything has settled
    always @(negedge CLK40)
    begin
        if (check_on)
        begin
            check_level(readout_wait, m_wait, "o_readout_wait");
            check_level(trigger_ack, m_ack, "o_trigger_ack");
            check_led(led, led_expected(m_slow_cnt >= SLOW_DIV / 2, m_fast_cnt >= FAST_DIV / 2));
        end
    end

    initial
    begin
        int base;
        int cycles;
        int acks;
        arst_n <= 1'b0;
        cmd_ready <= 1'b1;
        ext_trigger_enable <= 1'b1;
        trigger_enabled <= 1'b1;
        rx_enabled <= '1;
        fe_fifo_empty <= '1;
        rx_ready <= '0;
        rx_decoder_err <= '0;
        rx_fifo_overflow <= '0;
        rx_fifo_full <= '0;
        out_fifo_full <= 1'b0;
        clk_locked <= 1'b1;
        repeat (3) @(posedge CLK40);
        arst_n <= 1'b1;
        @(negedge CLK40);
        check_on <= 1'b1;

        // ready level high out of reset but no ack
        base = errors;
        for (int i = 0; i < 8; i++)
        begin
            @(negedge CLK40);
            check_level(readout_wait, 1'b0, "wait after reset");
            check_level(trigger_ack, 1'b0, "ack after reset");
            check_level(dut_i.fsm_i.fifo_ready, 1'b1, "internal ready after reset");
        end
        report_test("reset", base);

        // single command with every fifo empty
        base = errors;
        @(posedge CLK40);
        cmd_ready <= 1'b0;
        @(posedge CLK40);
        cmd_ready <= 1'b1;
        @(posedge CLK40);
        @(negedge CLK40);
        check_level(readout_wait, 1'b1, "wait after command edge");
        wait_for_ack(MAX_WAIT + NS + 10, cycles);
        if (cycles < MAX_WAIT || cycles > MAX_WAIT + NS + 3)
        begin
            errors++;
            $display("[ERROR] %0t ns: ack latency %0d outside %0d..%0d", $time, cycles,
                     MAX_WAIT, MAX_WAIT + NS + 3);
        end
        @(negedge CLK40);
        check_level(trigger_ack, 1'b0, "ack is a single pulse");
        report_test("empty drain", base);

        // random enables and empty flags with disabled channels mostly busy
        base = errors;
        acks = 0;
        for (int i = 0; i < 800; i++)
        begin
            @(posedge CLK40);
            rng = xorshift32(rng);
            if (rng[4:0] == 5'd0)
            begin
                rx_enabled <= rng[5 +: NC];
                if (rng[10:9] != 2'b00)
                    fe_fifo_empty <= ~rng[5 +: NC];
                else
                    fe_fifo_empty <= rng[11 +: NC];
            end
            if (rng[17:15] == 3'd0)
                cmd_ready <= ~cmd_ready;
            @(negedge CLK40);
            if (trigger_ack)
                acks++;
        end
        if (acks == 0)
        begin
            errors++;
            $display("random drain test never reached a trigger acknowledge");
        end
        @(posedge CLK40);
        rx_enabled <= '1;
        fe_fifo_empty <= '1;
        cmd_ready <= 1'b1;
        @(negedge CLK40);
        wait_idle(4 * MAX_WAIT);
        report_test("random drain", base);

        // enabled channel 0 never drains so only a disable ends the wait
        base = errors;
        @(posedge CLK40);
        fe_fifo_empty <= ~NC'(1);
        abort_by_disable(1'b1);
        abort_by_disable(1'b0);
        @(posedge CLK40);
        fe_fifo_empty <= '1;
        report_test("disable abort", base);

        // led status is checked every cycle by the model compare
        base = errors;
        for (int i = 0; i < 300; i++)
        begin
            @(posedge CLK40);
            rng = xorshift32(rng);
            rx_ready <= rng[0 +: NC];
            rx_decoder_err <= rng[4 +: NC];
            rx_fifo_overflow <= rng[8 +: NC] & rng[12 +: NC];
            rx_fifo_full <= rng[16 +: NC] & rng[20 +: NC];
            out_fifo_full <= rng[24] & rng[25];
            clk_locked <= rng[26] | rng[27];
        end
        @(negedge CLK40);
        report_test("status leds", base);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
